// File: source/ifu_pkg.sv
package ifu_pkg;

	// ******************************************************************
	// basic fetch types
	// ******************************************************************

	// instruction address, full 64-bit
	typedef logic [63:0] addr_t;
	// one uncompressed instruction
	typedef logic [31:0] inst_t;
	// one instruction memory beat, two instructions
	typedef logic [63:0] mem_word_t;

	// four-phase sequencer states
	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		REQ      = 3'd1,
		RELEASE  = 3'd2,
		DROP_REQ = 3'd3,
		FAULT    = 3'd4
	} fetch_state_t;

	// static prediction outcome of the predecode
	typedef enum logic [1:0] {
		PRED_SEQ         = 2'd0,
		PRED_BRANCH_BACK = 2'd1,
		PRED_JAL         = 2'd2
	} pred_kind_t;

	// ******************************************************************
	// rv64 encodings seen by the predecode
	// ******************************************************************

	// major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_t;

	// conditional branch funct3, inst[14:12]
	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} branch_funct3_t;

	// 010 and 011 are reserved under OPC_BRANCH
	function automatic logic is_branch_funct3(input logic [2:0] f3);
		return (f3 != 3'b010) && (f3 != 3'b011);
	endfunction

endpackage

// File: source/fetch_bus_if.sv
// four-phase instruction memory port
interface fetch_bus_if import ifu_pkg::*; ();

	// request level, held until ack is seen
	logic      req;
	// fetch address, stable while req is high
	addr_t     addr;
	// memory answer level
	logic      ack;
	// full 64-bit beat, valid while ack is high
	mem_word_t rdata;

	// fetch side, drives the request
	modport fsm (
		output req,
		output addr,
		input  ack
	);

	// memory side, answers the request
	modport mem (
		input  req,
		input  addr,
		output ack,
		output rdata
	);

endinterface

// File: source/fetch_fsm.sv
module fetch_fsm import ifu_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	fetch_bus_if.fsm bus,
	input  addr_t    fetch_pc,
	input  logic     redirect_valid,
	input  logic     buf_free,
	input  logic     expired,
	output logic     capture,
	output logic     timer_run,
	output logic     fetch_fault
);

	fetch_state_t state_q;
	fetch_state_t state_d;
	// address latched at request start, keeps addr stable through a drop
	addr_t        addr_q;

	// ******************************************************************
	// next state
	// ******************************************************************
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				// new request only once memory has released ack
				if (!redirect_valid && !bus.ack) begin
					state_d = REQ;
				end
			end
			REQ: begin
				// redirect beats a capture in the same cycle
				if (redirect_valid) begin
					state_d = DROP_REQ;
				end else if (bus.ack && buf_free) begin
					state_d = RELEASE;
				end else if (expired && !bus.ack) begin
					state_d = FAULT;
				end
			end
			DROP_REQ: begin
				// finish the handshake, data goes nowhere
				if (bus.ack) begin
					state_d = RELEASE;
				end else if (expired) begin
					state_d = FAULT;
				end
			end
			RELEASE: begin
				// redirect here: pc reloads this edge, start again from IDLE
				if (redirect_valid) begin
					state_d = IDLE;
				end else if (!bus.ack) begin
					state_d = REQ;
				end
			end
			FAULT: begin
				if (redirect_valid) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// take the pc only when a fresh request opens
	always_ff @(posedge clk) begin
		if (state_d == REQ && state_q != REQ) begin
			addr_q <= fetch_pc;
		end
	end

	// ******************************************************************
	// outputs
	// ******************************************************************
	assign bus.req  = (state_q == REQ) || (state_q == DROP_REQ);
	assign bus.addr = addr_q;

	// word accepted into the IF/ID buffer on this edge
	assign capture = (state_q == REQ) && bus.ack && buf_free && !redirect_valid;

	// count only while req is out and ack has not come
	assign timer_run = bus.req && !bus.ack;

	assign fetch_fault = (state_q == FAULT);

endmodule

// File: source/ack_wait_timer.sv
module ack_wait_timer #(
	parameter int ACK_TIMEOUT = 32
) (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	output logic expired
);

	// wide enough to hold ACK_TIMEOUT itself
	localparam int CNT_W = $clog2(ACK_TIMEOUT + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(ACK_TIMEOUT);

	logic [CNT_W-1:0] cnt_q;
	logic             expired_q;

	// saturating wait counter, any gap in run starts it over
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q     <= '0;
			expired_q <= 1'b0;
		end else if (!run) begin
			cnt_q     <= '0;
			expired_q <= 1'b0;
		end else begin
			if (cnt_q != LIMIT) begin
				cnt_q <= cnt_q + 1'b1;
			end
			// set at the end of the ACK_TIMEOUT-th counted cycle
			expired_q <= (cnt_q >= LIMIT - 1'b1);
		end
	end

	assign expired = expired_q;

endmodule

// File: source/next_pc_unit.sv
module next_pc_unit import ifu_pkg::*; #(
	parameter addr_t RESET_PC = 64'h8000_0000
) (
	input  logic      clk,
	input  logic      rst_n,
	input  mem_word_t rdata,
	input  logic      capture,
	input  logic      redirect_valid,
	input  addr_t     redirect_pc,
	output addr_t     fetch_pc,
	output inst_t     inst,
	output logic      pred_taken
);

	addr_t      pc_q;
	pred_kind_t kind;
	addr_t      imm_b;
	addr_t      imm_j;
	addr_t      target;

	// ******************************************************************
	// predecode
	// ******************************************************************

	// pc bit 2 picks the upper word of the beat
	assign inst = pc_q[2] ? rdata[63:32] : rdata[31:0];

	// sign-extended B and J immediates
	assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		kind = PRED_SEQ;
		case (inst[6:0])
			OPC_BRANCH: begin
				// backward taken, forward not taken
				if (is_branch_funct3(inst[14:12]) && inst[31]) begin
					kind = PRED_BRANCH_BACK;
				end
			end
			OPC_JAL: kind = PRED_JAL;
			default: kind = PRED_SEQ;
		endcase
	end

	// next fetch address
	always_comb begin
		case (kind)
			PRED_BRANCH_BACK: target = pc_q + imm_b;
			PRED_JAL:         target = pc_q + imm_j;
			default:          target = pc_q + 64'd4;
		endcase
	end

	assign pred_taken = (kind != PRED_SEQ);

	// ******************************************************************
	// fetch pc register
	// ******************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_PC;
		end else if (redirect_valid) begin
			// execute correction wins
			pc_q <= redirect_pc;
		end else if (capture) begin
			pc_q <= target;
		end
	end

	assign fetch_pc = pc_q;

endmodule

// File: source/fetch_buffer.sv
module fetch_buffer import ifu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  load,
	input  logic  flush,
	input  addr_t pc,
	input  inst_t inst,
	input  logic  pred_taken,
	input  logic  if_ready,
	output logic  buf_free,
	output logic  if_valid,
	output addr_t if_pc,
	output inst_t if_inst,
	output logic  if_pred_taken
);

	logic  valid_q;
	addr_t pc_q;
	inst_t inst_q;
	logic  pred_q;

	// valid bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
		end else if (if_ready) begin
			// drained by decode
			valid_q <= 1'b0;
		end
	end

	// payload, only moves on load
	always_ff @(posedge clk) begin
		if (load) begin
			pc_q   <= pc;
			inst_q <= inst;
			pred_q <= pred_taken;
		end
	end

	// empty, or emptied by decode on this edge
	assign buf_free = !valid_q || if_ready;

	assign if_valid      = valid_q;
	assign if_pc         = pc_q;
	assign if_inst       = inst_q;
	assign if_pred_taken = pred_q;

endmodule

// File: source/ifu_top.sv
module ifu_top import ifu_pkg::*; #(
	parameter addr_t RESET_PC    = 64'h8000_0000,
	parameter int    ACK_TIMEOUT = 32
) (
	input  logic      clk,
	input  logic      rst_n,
	// instruction memory, four-phase
	output logic      mem_req,
	output addr_t     mem_addr,
	input  logic      mem_ack,
	input  mem_word_t mem_rdata,
	// correction from execute
	input  logic      redirect_valid,
	input  addr_t     redirect_pc,
	// IF/ID
	output logic      if_valid,
	input  logic      if_ready,
	output addr_t     if_pc,
	output inst_t     if_inst,
	output logic      if_pred_taken,
	output logic      fetch_fault
);

	fetch_bus_if bus ();

	logic  capture;
	logic  timer_run;
	logic  expired;
	logic  buf_free;
	logic  pred_taken;
	addr_t fetch_pc;
	inst_t inst;

	// ******************************************************************
	// memory side of the bus onto plain ports
	// ******************************************************************
	assign mem_req   = bus.req;
	assign mem_addr  = bus.addr;
	assign bus.ack   = mem_ack;
	assign bus.rdata = mem_rdata;

	fetch_fsm u_fsm (
		.clk           (clk),
		.rst_n         (rst_n),
		.bus           (bus.fsm),
		.fetch_pc      (fetch_pc),
		.redirect_valid(redirect_valid),
		.buf_free      (buf_free),
		.expired       (expired),
		.capture       (capture),
		.timer_run     (timer_run),
		.fetch_fault   (fetch_fault)
	);

	ack_wait_timer #(
		.ACK_TIMEOUT(ACK_TIMEOUT)
	) u_timer (
		.clk    (clk),
		.rst_n  (rst_n),
		.run    (timer_run),
		.expired(expired)
	);

	next_pc_unit #(
		.RESET_PC(RESET_PC)
	) u_npc (
		.clk           (clk),
		.rst_n         (rst_n),
		.rdata         (bus.rdata),
		.capture       (capture),
		.redirect_valid(redirect_valid),
		.redirect_pc   (redirect_pc),
		.fetch_pc      (fetch_pc),
		.inst          (inst),
		.pred_taken    (pred_taken)
	);

	// redirect also empties the IF/ID slot
	fetch_buffer u_buf (
		.clk          (clk),
		.rst_n        (rst_n),
		.load         (capture),
		.flush        (redirect_valid),
		.pc           (fetch_pc),
		.inst         (inst),
		.pred_taken   (pred_taken),
		.if_ready     (if_ready),
		.buf_free     (buf_free),
		.if_valid     (if_valid),
		.if_pc        (if_pc),
		.if_inst      (if_inst),
		.if_pred_taken(if_pred_taken)
	);

endmodule

// File: test/ifu_checker.sv
// protocol checks on the fetch unit, bound into ifu_top
module ifu_checker import ifu_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input logic  req,
	input addr_t addr,
	input logic  ack,
	input logic  redirect_valid,
	input logic  if_valid,
	input logic  if_ready,
	input addr_t if_pc,
	input inst_t if_inst,
	input logic  if_pred_taken,
	input logic  fetch_fault
);

	// ******************************************************************
	// four-phase memory port
	// ******************************************************************

	// address held for the whole request
	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		req && $past(req) |-> $stable(addr))
		else $error("mem_addr moved while mem_req was high");

	// req drops only after an ack, or on a timeout
	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(req) |-> $past(ack) || fetch_fault)
		else $error("mem_req fell before mem_ack rose");

	// new request only once ack was seen low
	req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(req) |-> !$past(ack))
		else $error("mem_req rose while mem_ack was high");

	// ******************************************************************
	// IF/ID and fault
	// ******************************************************************
	payload_hold: assert property (@(posedge clk) disable iff (!rst_n)
		if_valid && !if_ready |=> $stable(if_pc) && $stable(if_inst)
			&& $stable(if_pred_taken))
		else $error("IF/ID payload changed under back-pressure");

	// fault sticks with req low until execute redirects
	fault_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_fault && !redirect_valid |=> fetch_fault && !req)
		else $error("fetch_fault dropped or mem_req rose without a redirect");

endmodule

bind ifu_top ifu_checker u_chk (
	.clk           (clk),
	.rst_n         (rst_n),
	.req           (mem_req),
	.addr          (mem_addr),
	.ack           (mem_ack),
	.redirect_valid(redirect_valid),
	.if_valid      (if_valid),
	.if_ready      (if_ready),
	.if_pc         (if_pc),
	.if_inst       (if_inst),
	.if_pred_taken (if_pred_taken),
	.fetch_fault   (fetch_fault)
);

// File: test/tb_ifu.sv
module tb_ifu import ifu_pkg::*; ();

	localparam addr_t BASE        = 64'h8000_0000;
	localparam int    ACK_TO      = 16;
	localparam int    IMG_WORDS   = 64;
	// outside the image, memory never answers here
	localparam addr_t NO_ACK_ADDR = 64'h8000_1000;
	// transfers over all tests, times a worst-case fetch
	localparam int    TOTAL_XFERS = 8 + 48 + 40 + 3 * 6 + 6 + 120;
	localparam int    CYCLE_LIMIT = 16 + (TOTAL_XFERS + 8) * (ACK_TO + 16);

	logic      clk = 1'b0;
	logic      rst_n;
	logic      mem_req;
	addr_t     mem_addr;
	logic      mem_ack;
	mem_word_t mem_rdata;
	logic      redirect_valid;
	addr_t     redirect_pc;
	logic      if_valid;
	logic      if_ready;
	addr_t     if_pc;
	inst_t     if_inst;
	logic      if_pred_taken;
	logic      fetch_fault;

	mem_word_t   image [IMG_WORDS];
	logic [31:0] lfsr = 32'h80ac_05cd;
	logic        pending;
	logic        req_seen;
	int          wait_cnt;
	logic        rand_ready = 1'b0;
	logic        hold_ready = 1'b0;
	addr_t       exp_pc = BASE;
	addr_t       exp_fetch = BASE;
	int          xfer_count = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycles = 0;

	ifu_top #(.RESET_PC(BASE), .ACK_TIMEOUT(ACK_TO)) u_dut (.*);

	always #2 clk = ~clk;

	// ******************************************************************
	// helpers: lfsr, encoders, image
	// ******************************************************************

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic in_image(input addr_t a);
		return (a >= BASE) && (a < BASE + 64'(IMG_WORDS * 8));
	endfunction

	function automatic int word_index(input addr_t a);
		return int'((a - BASE) >> 3);
	endfunction

	function automatic inst_t img_inst(input addr_t a);
		mem_word_t w;
		w = in_image(a) ? image[word_index(a)] : '0;
		return a[2] ? w[63:32] : w[31:0];
	endfunction

	task automatic put_inst(input addr_t a, input inst_t i);
		if (a[2]) image[word_index(a)][63:32] = i;
		else image[word_index(a)][31:0] = i;
	endtask

	// addi x1, x0 with an immediate folded from the whole address
	function automatic inst_t fill_inst(input addr_t a);
		logic [11:0] f;
		f = a[11:0] ^ a[23:12] ^ a[35:24] ^ a[47:36] ^ a[59:48] ^ {8'd0, a[63:60]};
		return {f, 5'd0, 3'b000, 5'd1, 7'b0010011};
	endfunction

	function automatic inst_t enc_branch(input logic [2:0] f3, input logic [12:0] off);
		return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic inst_t enc_jal(input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
	endfunction

	// ******************************************************************
	// reference predictor
	// ******************************************************************
	function automatic logic ref_taken(input inst_t i);
		if (i[6:0] == OPC_JAL) return 1'b1;
		return (i[6:0] == OPC_BRANCH) && (i[14:12] != 3'b010)
			&& (i[14:12] != 3'b011) && i[31];
	endfunction

	function automatic addr_t ref_next_pc(input addr_t pc, input inst_t i);
		addr_t bimm;
		addr_t jimm;
		bimm = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
		jimm = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
		if (!ref_taken(i)) return pc + 64'd4;
		return (i[6:0] == OPC_JAL) ? pc + jimm : pc + bimm;
	endfunction

	// ******************************************************************
	// compare tasks
	// ******************************************************************
	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_inst(input string name, input inst_t got, input inst_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// sampled mid-cycle, where every driven value has settled
	always @(negedge clk) begin
		if (rst_n && redirect_valid) begin
			exp_pc = redirect_pc;
			exp_fetch = redirect_pc;
		end else if (rst_n && if_valid && if_ready) begin
			check_addr("if_pc", if_pc, exp_pc);
			check_inst("if_inst", if_inst, img_inst(exp_pc));
			check_flag("if_pred_taken", if_pred_taken, ref_taken(img_inst(exp_pc)));
			exp_pc = ref_next_pc(exp_pc, img_inst(exp_pc));
			xfer_count++;
		end
	end

	// ******************************************************************
	// memory model and decode side, driven after each edge
	// ******************************************************************
	always @(posedge clk) begin
		#1;
		if (!rst_n) begin
			mem_ack = 1'b0;
			pending = 1'b0;
			req_seen = 1'b0;
			wait_cnt = 0;
			if_ready = 1'b0;
		end else begin
			if (hold_ready) if_ready = 1'b0;
			else if (rand_ready) if_ready = (take_bits(1) != 0);
			else if_ready = 1'b1;
			// req low closes the previous request
			if (!mem_req) req_seen = 1'b0;
			if (mem_ack) begin
				if (!mem_req) mem_ack = 1'b0;
			end else if (pending) begin
				if (wait_cnt <= 1) begin
					mem_ack = 1'b1;
					mem_rdata = image[word_index(mem_addr)];
					pending = 1'b0;
				end else begin
					wait_cnt--;
				end
			end else if (mem_req && !req_seen) begin
				// each new request follows the reference fetch order
				req_seen = 1'b1;
				check_addr("mem_addr", mem_addr, exp_fetch);
				exp_fetch = ref_next_pc(exp_fetch, img_inst(exp_fetch));
				if (in_image(mem_addr)) begin
					// ack comes 1 to 4 cycles later
					pending = 1'b1;
					wait_cnt = 1 + int'(take_bits(2));
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped: no progress within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	// ******************************************************************
	// stimulus
	// ******************************************************************
	task automatic wait_xfers(input int n);
		int target;
		target = xfer_count + n;
		while (xfer_count < target) @(negedge clk);
	endtask

	task automatic send_redirect(input addr_t pc);
		@(posedge clk);
		hold_ready = 1'b1;
		#1;
		redirect_valid = 1'b1;
		redirect_pc = pc;
		@(posedge clk);
		hold_ready = 1'b0;
		#1;
		redirect_valid = 1'b0;
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - err_before);
		end else begin
			$display("test %0d %s: passed", tests_run, name);
		end
	endtask

	initial begin
		int e0;
		int n0;
		rst_n = 1'b0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		if_ready = 1'b0;
		for (int w = 0; w < IMG_WORDS * 2; w++) begin
			put_inst(BASE + 64'(w * 4), fill_inst(BASE + 64'(w * 4)));
		end
		// forward branch, then jal into a loop closed by a backward blt
		put_inst(BASE + 64'h40, enc_branch(3'b001, 13'd16));
		put_inst(BASE + 64'h80, enc_jal(21'h40));
		put_inst(BASE + 64'h104, enc_branch(3'b100, -13'sd68));
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		e0 = errors;
		wait_xfers(8);
		report_test("straight line", e0);

		e0 = errors;
		wait_xfers(48);
		report_test("branch and jal", e0);

		e0 = errors;
		rand_ready = 1'b1;
		wait_xfers(40);
		rand_ready = 1'b0;
		report_test("ready back-pressure", e0);

		e0 = errors;
		do @(negedge clk); while (!(mem_req && pending && wait_cnt >= 2));
		send_redirect(BASE + 64'h14);
		wait_xfers(6);
		do @(negedge clk); while (!(mem_req && pending && wait_cnt <= 1 && !if_valid));
		send_redirect(BASE + 64'h30);
		wait_xfers(6);
		// word is captured on the next edge
		// redirect then hits the release phase and flushes it
		do @(negedge clk); while (!(mem_req && mem_ack));
		send_redirect(BASE + 64'h100);
		wait_xfers(6);
		report_test("redirect", e0);

		e0 = errors;
		send_redirect(NO_ACK_ADDR);
		n0 = xfer_count;
		do @(negedge clk); while (!fetch_fault);
		check_flag("mem_req", mem_req, 1'b0);
		if (xfer_count != n0) begin
			errors++;
			$display("a transfer appeared while fetching from the non-acking address");
		end
		send_redirect(BASE + 64'h24);
		// fault clears on the redirect edge
		check_flag("fetch_fault", fetch_fault, 1'b0);
		wait_xfers(6);
		report_test("fetch fault", e0);

		e0 = errors;
		rand_ready = 1'b1;
		wait_xfers(120);
		report_test("long random run", e0);

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run,
			tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: all.f
source/ifu_pkg.sv
source/fetch_bus_if.sv
source/fetch_fsm.sv
source/ack_wait_timer.sv
source/next_pc_unit.sv
source/fetch_buffer.sv
source/ifu_top.sv
test/ifu_checker.sv
test/tb_ifu.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tb_ifu \
	-f all.f \
	-Mdir obj_dir -o tb_ifu

./obj_dir/tb_ifu | tee sim.log

if grep -q "All tests passed!" sim.log; then
	exit 0
fi
exit 1
